//--- design/gmii_rx_params.svh
// compile-time constants; FIFO depth must be a power of two and at least one maximum frame
`ifndef GMII_RX_PARAMS_SVH
`define GMII_RX_PARAMS_SVH

// preamble fill byte and start-of-frame delimiter as seen on rxd
`define GMII_RX_PREAMBLE 8'h55
`define GMII_RX_SFD 8'hD5

// CRC-32 remainder left after running over data plus a correct FCS
// given in the bit order of the normal (non-reflected) polynomial
`define GMII_RX_CRC_RESIDUE 32'hC704DD7B

// frame store size in bytes
`define GMII_RX_FIFO_DEPTH 4096

// largest frame the store reserves room for, FCS included
`define GMII_RX_MAX_FRAME 1526

// ceiling of the consumer credit counter
`define GMII_RX_CREDIT_MAX 16

`endif

//--- design/gmii_rx_pkg.sv
// shared types only; widths follow the limits in gmii_rx_params.svh, which must be on the include path
`include "gmii_rx_params.svh"

package gmii_rx_pkg;

    // one GMII data byte as it moves through the receive path
    typedef logic [7:0] rx_byte_t;

    // per-frame result queued by the emitter
    // 1 means the FCS matched and no rx_er was seen
    typedef logic verdict_t;

    // consumer byte credits, 0 up to the credit ceiling inclusive
    typedef logic [$clog2(`GMII_RX_CREDIT_MAX + 1)-1:0] credit_t;

    // frame store occupancy in bytes, 0 up to the full depth inclusive
    typedef logic [$clog2(`GMII_RX_FIFO_DEPTH + 1)-1:0] fifo_level_t;

endpackage

//--- design/gmii_rx_top.sv
// single clock domain on clk_io; FCS is passed through, frames refused by the store are only counted
`timescale 1ns/10ps

module gmii_rx_top (
    input  logic                  clk_io,
    input  logic                  arst_n,
    input  gmii_rx_pkg::rx_byte_t rxd,
    input  logic                  rx_dv,
    input  logic                  rx_er,
    input  logic                  out_credit,
    output logic                  out_valid,
    output gmii_rx_pkg::rx_byte_t out_data,
    output logic                  out_last,
    output logic                  out_good,
    output logic [15:0]           rx_frames_dropped
);

    // captured pins {rx_er, rx_dv, rxd}
    logic [9:0] cap_q;

    // delineated stream, shared by store and checker
    logic                  byte_valid;
    gmii_rx_pkg::rx_byte_t byte_data;
    logic                  byte_first;
    logic                  byte_last;
    logic                  frame_err;

    logic fcs_done;
    logic fcs_ok;

    // store to emitter
    logic                  frame_stored;
    logic                  rd_valid;
    gmii_rx_pkg::rx_byte_t rd_data;
    logic                  rd_last;
    logic                  rd_ready;

    ssio_sdr_in #(
        .WIDTH(10)
    ) u_capture (
        .clk_io(clk_io),
        .d     ({rx_er, rx_dv, rxd}),
        .q     (cap_q)
    );

    rx_frame_delineator u_delineator (
        .clk_io    (clk_io),
        .arst_n    (arst_n),
        .d_in      (cap_q),
        .byte_valid(byte_valid),
        .byte_data (byte_data),
        .byte_first(byte_first),
        .byte_last (byte_last),
        .frame_err (frame_err)
    );

    rx_fcs_checker u_fcs (
        .clk_io    (clk_io),
        .arst_n    (arst_n),
        .byte_valid(byte_valid),
        .byte_data (byte_data),
        .byte_first(byte_first),
        .byte_last (byte_last),
        .fcs_done  (fcs_done),
        .fcs_ok    (fcs_ok)
    );

    rx_frame_store u_store (
        .clk_io           (clk_io),
        .arst_n           (arst_n),
        .byte_valid       (byte_valid),
        .byte_data        (byte_data),
        .byte_first       (byte_first),
        .byte_last        (byte_last),
        .frame_stored     (frame_stored),
        .rx_frames_dropped(rx_frames_dropped),
        .rd_valid         (rd_valid),
        .rd_data          (rd_data),
        .rd_last          (rd_last),
        .rd_ready         (rd_ready)
    );

    rx_frame_emitter u_emitter (
        .clk_io      (clk_io),
        .arst_n      (arst_n),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .rd_last     (rd_last),
        .rd_ready    (rd_ready),
        .fcs_done    (fcs_done),
        .fcs_ok      (fcs_ok),
        .frame_err   (frame_err),
        .frame_stored(frame_stored),
        .out_credit  (out_credit),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_last    (out_last),
        .out_good    (out_good)
    );

endmodule

//--- design/rx_fcs_checker.sv
// checks Ethernet CRC-32 over payload and FCS together; bytes must arrive least significant bit first
`timescale 1ns/10ps
`include "gmii_rx_params.svh"

module rx_fcs_checker (
    input  logic                  clk_io,
    input  logic                  arst_n,
    input  logic                  byte_valid,
    input  gmii_rx_pkg::rx_byte_t byte_data,
    input  logic                  byte_first,
    input  logic                  byte_last,
    output logic                  fcs_done,
    output logic                  fcs_ok
);

    // reflected form of the 802.3 polynomial
    localparam logic [31:0] crc_poly = 32'hEDB88320;

    logic [31:0] crc_q;
    logic [31:0] crc_seed;
    logic [31:0] crc_next;
    logic [31:0] crc_rev;

    // one byte through the reflected CRC, bit serial
    function automatic logic [31:0] crc32_byte(
        input logic [31:0]           crc,
        input gmii_rx_pkg::rx_byte_t data
    );
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ crc_poly) : (c >> 1);
        end
        return c;
    endfunction

    // first byte of a frame starts from all ones
    assign crc_seed = byte_first ? 32'hFFFF_FFFF : crc_q;
    assign crc_next = crc32_byte(crc_seed, byte_data);

    // residue constant is written in normal bit order,
    // so flip the reflected register before comparing
    always_comb begin
        crc_rev = {<<{crc_next}};
    end

    always_ff @(posedge clk_io or negedge arst_n) begin
        if (!arst_n) begin
            crc_q    <= 32'hFFFF_FFFF;
            fcs_done <= 1'b0;
            fcs_ok   <= 1'b0;
        end else begin
            if (byte_valid) begin
                crc_q <= crc_next;
            end
            // result one cycle after the last byte,
            // FCS bytes included in the running CRC
            fcs_done <= byte_valid & byte_last;
            if (byte_valid && byte_last) begin
                fcs_ok <= (crc_rev == `GMII_RX_CRC_RESIDUE);
            end
        end
    end

endmodule

//--- design/rx_frame_delineator.sv
// expects d_in = {rx_er, rx_dv, rxd}; needs a preamble byte before the SFD, forwards bytes after it
`timescale 1ns/10ps
`include "gmii_rx_params.svh"

module rx_frame_delineator (
    input  logic                  clk_io,
    input  logic                  arst_n,
    input  logic [9:0]            d_in,
    output logic                  byte_valid,
    output gmii_rx_pkg::rx_byte_t byte_data,
    output logic                  byte_first,
    output logic                  byte_last,
    output logic                  frame_err
);

    typedef enum logic [1:0] {
        st_idle,
        st_preamble,
        st_frame,
        st_discard
    } state_t;

    state_t state;

    // split of the captured pin word
    gmii_rx_pkg::rx_byte_t rxd;
    logic rx_dv;
    logic rx_er;

    // one-byte hold so the final byte can be tagged when dv drops
    gmii_rx_pkg::rx_byte_t hold_q;
    logic hold_valid;
    logic first_q;
    // sticky rx_er over the frame body
    logic err_q;

    assign rxd   = d_in[7:0];
    assign rx_dv = d_in[8];
    assign rx_er = d_in[9];

    always_ff @(posedge clk_io or negedge arst_n) begin
        if (!arst_n) begin
            state      <= st_idle;
            hold_valid <= 1'b0;
            first_q    <= 1'b0;
            err_q      <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    // a frame has to open with preamble, anything else is junk
                    if (rx_dv) begin
                        state <= (rxd == `GMII_RX_PREAMBLE) ? st_preamble : st_discard;
                    end
                end
                st_preamble: begin
                    if (!rx_dv) begin
                        state <= st_idle;
                    end else if (rxd == `GMII_RX_SFD) begin
                        state   <= st_frame;
                        first_q <= 1'b1;
                        err_q   <= 1'b0;
                    end else if (rxd != `GMII_RX_PREAMBLE) begin
                        state <= st_discard;
                    end
                end
                st_frame: begin
                    if (rx_dv) begin
                        hold_valid <= 1'b1;
                        err_q      <= err_q | rx_er;
                        // held byte goes out this cycle, so first is spent
                        if (hold_valid) begin
                            first_q <= 1'b0;
                        end
                    end else begin
                        state      <= st_idle;
                        hold_valid <= 1'b0;
                        first_q    <= 1'b0;
                    end
                end
                default: begin
                    // bad preamble, wait out the rest of the burst
                    if (!rx_dv) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // byte payload, refreshed with every frame byte
    always_ff @(posedge clk_io) begin
        if (state == st_frame && rx_dv) begin
            hold_q <= rxd;
        end
    end

    // held byte leaves once the next pin word tells whether it was the last
    assign byte_valid = hold_valid;
    assign byte_data  = hold_q;
    assign byte_first = hold_valid & first_q;
    assign byte_last  = hold_valid & ~rx_dv;
    assign frame_err  = hold_valid & ~rx_dv & err_q;

    // forwarded bytes only ever come from inside a delimited frame
    a_valid_in_frame: assert property (@(posedge clk_io) disable iff (!arst_n)
        byte_valid |-> state == st_frame)
        else $error("byte forwarded outside a frame");

    // byte_first marks exactly the opening byte of each run of forwarded bytes
    a_first_opens: assert property (@(posedge clk_io) disable iff (!arst_n)
        byte_valid |-> (byte_first == !$past(byte_valid)))
        else $error("byte_first missing on the opening byte or set inside a frame");

endmodule

//--- design/rx_frame_emitter.sv
// outputs are combinational from store and counters; consumer returns one credit per out_credit pulse
`timescale 1ns/10ps
`include "gmii_rx_params.svh"

module rx_frame_emitter (
    input  logic                  clk_io,
    input  logic                  arst_n,
    input  logic                  rd_valid,
    input  gmii_rx_pkg::rx_byte_t rd_data,
    input  logic                  rd_last,
    output logic                  rd_ready,
    input  logic                  fcs_done,
    input  logic                  fcs_ok,
    input  logic                  frame_err,
    input  logic                  frame_stored,
    input  logic                  out_credit,
    output logic                  out_valid,
    output gmii_rx_pkg::rx_byte_t out_data,
    output logic                  out_last,
    output logic                  out_good
);

    localparam int addr_w = $clog2(`GMII_RX_FIFO_DEPTH);

    // one entry per stored frame, and a frame holds at least one byte,
    // so store depth bounds the queue
    gmii_rx_pkg::verdict_t vq_mem [`GMII_RX_FIFO_DEPTH];
    logic [addr_w-1:0] vq_wr;
    logic [addr_w-1:0] vq_rd;
    gmii_rx_pkg::fifo_level_t vq_count;
    logic vq_push;
    logic vq_pop;

    gmii_rx_pkg::credit_t credits;
    logic credit_inc;
    logic send;
    // frame_err is valid with the last byte, fcs_done a cycle later
    logic err_d1;

    assign vq_push = frame_stored & fcs_done;

    // last byte waits for its verdict, every byte waits for a credit
    assign rd_ready = (credits != '0) & (~rd_last | (vq_count != '0));
    assign send     = rd_valid & rd_ready;
    assign vq_pop   = send & rd_last;

    // a pulse while sending cancels out, otherwise saturate at the ceiling
    assign credit_inc = out_credit &
                        (send | (credits != gmii_rx_pkg::credit_t'(`GMII_RX_CREDIT_MAX)));

    assign out_valid = send;
    assign out_data  = rd_data;
    assign out_last  = rd_last;
    assign out_good  = rd_last & vq_mem[vq_rd];

    always_ff @(posedge clk_io or negedge arst_n) begin
        if (!arst_n) begin
            vq_wr    <= '0;
            vq_rd    <= '0;
            vq_count <= '0;
            credits  <= '0;
            err_d1   <= 1'b0;
        end else begin
            err_d1 <= frame_err;
            if (vq_push) begin
                vq_wr <= vq_wr + 1'b1;
            end
            if (vq_pop) begin
                vq_rd <= vq_rd + 1'b1;
            end
            vq_count <= vq_count + gmii_rx_pkg::fifo_level_t'(vq_push)
                                 - gmii_rx_pkg::fifo_level_t'(vq_pop);
            credits <= credits + gmii_rx_pkg::credit_t'(credit_inc)
                               - gmii_rx_pkg::credit_t'(send);
        end
    end

    // verdict storage
    always_ff @(posedge clk_io) begin
        if (vq_push) begin
            vq_mem[vq_wr] <= fcs_ok & ~err_d1;
        end
    end

    // out of credit and none returned, so nothing may go out next cycle
    a_no_send_broke: assert property (@(posedge clk_io) disable iff (!arst_n)
        (credits == '0 && !out_credit) |=> !out_valid)
        else $error("byte sent without consumer credit");

endmodule

//--- design/rx_frame_store.sv
// admits a frame only with room for a maximum frame at its start; longer frames are not supported
`timescale 1ns/10ps
`include "gmii_rx_params.svh"

module rx_frame_store (
    input  logic                  clk_io,
    input  logic                  arst_n,
    input  logic                  byte_valid,
    input  gmii_rx_pkg::rx_byte_t byte_data,
    input  logic                  byte_first,
    input  logic                  byte_last,
    output logic                  frame_stored,
    output logic [15:0]           rx_frames_dropped,
    output logic                  rd_valid,
    output gmii_rx_pkg::rx_byte_t rd_data,
    output logic                  rd_last,
    input  logic                  rd_ready
);

    localparam int addr_w = $clog2(`GMII_RX_FIFO_DEPTH);

    // byte plus end-of-frame marker
    logic [8:0] mem [`GMII_RX_FIFO_DEPTH];

    logic [addr_w-1:0] wr_ptr;
    logic [addr_w-1:0] rd_ptr;
    gmii_rx_pkg::fifo_level_t level;
    gmii_rx_pkg::fifo_level_t free_space;
    logic admit_now;
    logic admit_q;
    logic wr_en;
    logic rd_en;
    logic full;

    assign free_space = gmii_rx_pkg::fifo_level_t'(`GMII_RX_FIFO_DEPTH) - level;
    assign full       = (free_space == '0);
    // decision taken on the first byte and kept for the rest of the frame
    assign admit_now  = free_space >= gmii_rx_pkg::fifo_level_t'(`GMII_RX_MAX_FRAME);
    assign wr_en      = byte_valid & (byte_first ? admit_now : admit_q);

    // read side, a byte written last cycle is already visible
    assign rd_valid = (level != '0);
    assign rd_en    = rd_valid & rd_ready;
    assign {rd_last, rd_data} = mem[rd_ptr];

    always_ff @(posedge clk_io or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr            <= '0;
            rd_ptr            <= '0;
            level             <= '0;
            admit_q           <= 1'b0;
            frame_stored      <= 1'b0;
            rx_frames_dropped <= '0;
        end else begin
            if (byte_valid && byte_first) begin
                admit_q <= admit_now;
                // refused frame, count it and saturate
                if (!admit_now && rx_frames_dropped != 16'hFFFF) begin
                    rx_frames_dropped <= rx_frames_dropped + 16'd1;
                end
            end
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            level <= level + gmii_rx_pkg::fifo_level_t'(wr_en)
                           - gmii_rx_pkg::fifo_level_t'(rd_en);
            // lines up with fcs_done from the checker
            frame_stored <= wr_en & byte_last;
        end
    end

    always_ff @(posedge clk_io) begin
        if (wr_en) begin
            mem[wr_ptr] <= {byte_last, byte_data};
        end
    end

    // admission headroom must cover every byte of an admitted frame
    a_no_write_full: assert property (@(posedge clk_io) disable iff (!arst_n)
        wr_en |-> !full)
        else $error("frame store written while full");

endmodule

//--- design/ssio_sdr_in.sv
// generic SDR capture only, no vendor clock buffers; clk_io must be the forwarded receive clock
`timescale 1ns/10ps

module ssio_sdr_in #(
    // number of parallel pins captured
    parameter int WIDTH = 1
) (
    input  logic             clk_io,
    input  logic [WIDTH-1:0] d,
    output logic [WIDTH-1:0] q
);

    // capture flops meant to sit in the I/O cells
    // the initial value keeps simulation free of X before the first edge
    // no reset, these just follow the pins every cycle
    (* IOB = "TRUE" *)
    logic [WIDTH-1:0] q_reg = '0;

    // one register stage from pin to fabric
    always_ff @(posedge clk_io) begin
        q_reg <= d;
    end

    assign q = q_reg;

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run the GMII receive bench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_gmii_rx -f src.f -o sim_gmii_rx

# the log decides the result, so a nonzero simulator exit must not end the script here
./obj_dir/sim_gmii_rx > sim.log 2>&1 || true
cat sim.log

if grep -q "=== PASS ===" sim.log; then
    exit 0
fi
echo "simulation did not pass"
exit 1

//--- src.f
+incdir+design
design/gmii_rx_pkg.sv
design/ssio_sdr_in.sv
design/rx_frame_delineator.sv
design/rx_fcs_checker.sv
design/rx_frame_store.sv
design/rx_frame_emitter.sv
design/gmii_rx_top.sv
verification/rx_scoreboard.sv
verification/tb_gmii_rx.sv

//--- verification/rx_scoreboard.sv
// checks uut output against queued {good, last, data} words in order; models credits by the handshake rule
`timescale 1ns/10ps
`include "gmii_rx_params.svh"

module rx_scoreboard (
    input logic                  clk_io,
    input logic                  arst_n,
    input logic                  out_credit,
    input logic                  out_valid,
    input gmii_rx_pkg::rx_byte_t out_data,
    input logic                  out_last,
    input logic                  out_good,
    // per-test bookkeeping from the bench
    input logic                  test_end,
    input int                    test_num,
    input int                    extra_errors
);

    // expected bytes, oldest first
    logic [9:0] exp_q[$];
    logic [9:0] exp_word;

    // consumer credits as the emitter should hold them
    int credit_level = 0;
    int bytes_seen = 0;
    int error_count = 0;
    int tests_failed = 0;
    int errors_at_last_test = 0;
    int errs;

    task add_byte(input gmii_rx_pkg::rx_byte_t d, input logic last, input logic good);
        exp_q.push_back({good, last, d});
    endtask

    function int pending_count();
        return exp_q.size();
    endfunction

    always @(posedge clk_io) begin
        if (arst_n && out_valid) begin
            bytes_seen++;
            if (credit_level == 0) begin
                $display("Fail %0t: byte %02h sent with no credit left", $time, out_data);
                error_count++;
            end
            if (exp_q.size() == 0) begin
                $display("Fail %0t: unexpected byte %02h, no frame pending", $time, out_data);
                error_count++;
            end else begin
                exp_word = exp_q.pop_front();
                if (out_data != exp_word[7:0] || out_last != exp_word[8]) begin
                    $display("Fail %0t: got data %02h last %0b, expected %02h last %0b",
                             $time, out_data, out_last, exp_word[7:0], exp_word[8]);
                    error_count++;
                end else if (out_last && out_good != exp_word[9]) begin
                    $display("Fail %0t: verdict %0b on last byte, expected %0b",
                             $time, out_good, exp_word[9]);
                    error_count++;
                end
            end
        end
        // a pulse together with a send leaves the count alone
        if (!arst_n) begin
            credit_level = 0;
        end else if (out_credit && !out_valid && credit_level < `GMII_RX_CREDIT_MAX) begin
            credit_level++;
        end else if (!out_credit && out_valid && credit_level > 0) begin
            credit_level--;
        end
        // one line per finished test
        if (test_end) begin
            errs = error_count + extra_errors - errors_at_last_test;
            errors_at_last_test = error_count + extra_errors;
            if (errs != 0) begin
                tests_failed++;
            end
            $display("test %0d: %s, %0d errors", test_num, (errs == 0) ? "ok" : "failed", errs);
        end
    end

endmodule

//--- verification/tb_gmii_rx.sv
// fixed-seed frame bench for gmii_rx_top; FCS and verdicts come from a local CRC-32 model
`timescale 1ns/10ps
`include "gmii_rx_params.svh"

module tb_gmii_rx;

    logic clk_io = 1'b0;
    logic arst_n = 1'b0;
    gmii_rx_pkg::rx_byte_t rxd = '0;
    logic rx_dv = 1'b0;
    logic rx_er = 1'b0;
    logic out_credit = 1'b0;
    logic out_valid;
    logic out_last;
    logic out_good;
    gmii_rx_pkg::rx_byte_t out_data;
    logic [15:0] rx_frames_dropped;

    logic test_end = 1'b0;
    int test_num = 1;
    int bench_errors = 0;
    int seed = 57;
    int cycles = 0;
    int cycle_limit = 2000;
    // credit return, 0 withheld, 1 dense, 2 sparse
    logic [1:0] credit_mode = 2'd0;
    logic [2:0] credit_rand [256];
    logic [7:0] credit_idx = '0;
    // bytes of the frame being built, FCS included
    gmii_rx_pkg::rx_byte_t frame_q[$];
    int lvl;
    int pred_drops;
    int drops_before;

    gmii_rx_top uut (
        .clk_io(clk_io), .arst_n(arst_n), .rxd(rxd), .rx_dv(rx_dv), .rx_er(rx_er),
        .out_credit(out_credit), .out_valid(out_valid), .out_data(out_data),
        .out_last(out_last), .out_good(out_good), .rx_frames_dropped(rx_frames_dropped)
    );

    rx_scoreboard sb (
        .clk_io(clk_io), .arst_n(arst_n), .out_credit(out_credit), .out_valid(out_valid),
        .out_data(out_data), .out_last(out_last), .out_good(out_good),
        .test_end(test_end), .test_num(test_num), .extra_errors(bench_errors)
    );

    initial begin
        forever #4 clk_io = ~clk_io;
    end

    // reflected CRC-32 with final inversion over the first n queued bytes
    function automatic logic [31:0] crc32_ref(input int n);
        logic [31:0] c;
        c = 32'hFFFF_FFFF;
        for (int i = 0; i < n; i++) begin
            c = c ^ {24'h0, frame_q[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    // FCS travels least significant byte first
    function automatic logic fcs_matches();
        int n;
        n = frame_q.size();
        return crc32_ref(n - 4) == {frame_q[n-1], frame_q[n-2], frame_q[n-3], frame_q[n-4]};
    endfunction

    task build_frame(input int len);
        logic [31:0] fcs;
        frame_q.delete();
        repeat (len) frame_q.push_back(8'($random(seed)));
        fcs = crc32_ref(len);
        for (int i = 0; i < 4; i++) begin
            frame_q.push_back(fcs[8*i +: 8]);
        end
    endtask

    task expect_frame(input logic good);
        foreach (frame_q[i]) begin
            sb.add_byte(frame_q[i], i == frame_q.size() - 1, good);
        end
    endtask

    // pre_len below zero sends the bytes raw, with no preamble or SFD
    task drive_frame(input int pre_len, input int er_at);
        cycle_limit += 4 * (pre_len + frame_q.size() + 16);
        for (int i = 0; i <= pre_len; i++) begin
            @(posedge clk_io);
            rxd   <= (i == pre_len) ? `GMII_RX_SFD : `GMII_RX_PREAMBLE;
            rx_dv <= 1'b1;
        end
        foreach (frame_q[i]) begin
            @(posedge clk_io);
            rxd   <= frame_q[i];
            rx_dv <= 1'b1;
            rx_er <= (i == er_at);
        end
        @(posedge clk_io);
        rxd   <= '0;
        rx_dv <= 1'b0;
        rx_er <= 1'b0;
        // inter-frame gap
        repeat (11) @(posedge clk_io);
    endtask

    task send_good();
        build_frame(46 + ($random(seed) & 63));
        expect_frame(fcs_matches());
        drive_frame(1 + ($random(seed) & 7), -1);
    endtask

    task wait_drained();
        while (sb.pending_count() != 0) @(posedge clk_io);
        repeat (20) @(posedge clk_io);
    endtask

    task end_test();
        test_end <= 1'b1;
        @(posedge clk_io);
        test_end <= 1'b0;
        @(posedge clk_io);
        test_num <= test_num + 1;
    endtask

    // credit pulses from a pattern table, one entry per cycle
    always @(posedge clk_io or negedge arst_n) begin
        if (!arst_n) begin
            out_credit <= 1'b0;
        end else begin
            credit_idx <= credit_idx + 8'd1;
            if (credit_mode == 2'd1) begin
                out_credit <= (credit_rand[credit_idx] != 3'd0);
            end else if (credit_mode == 2'd2) begin
                out_credit <= credit_rand[credit_idx][0];
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    always @(posedge clk_io) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, %0d expected bytes never came out",
                     cycles, sb.pending_count());
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        foreach (credit_rand[i]) credit_rand[i] = 3'($random(seed));
        repeat (8) @(posedge clk_io);
        arst_n <= 1'b1;

        // good frames held back, then released
        repeat (3) send_good();
        repeat (50) @(posedge clk_io);
        if (sb.bytes_seen != 0) begin
            $display("Fail %0t: %0d bytes out with credits withheld", $time, sb.bytes_seen);
            bench_errors++;
        end
        credit_mode <= 2'd1;
        repeat (3) send_good();
        wait_drained();
        end_test();

        // one corrupted payload byte, then rx_er in the middle of a frame
        build_frame(60);
        frame_q[3] ^= 8'h40;
        expect_frame(fcs_matches());
        drive_frame(7, -1);
        build_frame(60);
        expect_frame(1'b0);
        drive_frame(3, 10);
        send_good();
        wait_drained();
        end_test();

        // idle burst without preamble, then a preamble cut by a wrong byte
        frame_q = {8'h00, 8'h55, 8'hD5, 8'h17, 8'h99};
        drive_frame(-1, -1);
        frame_q = {8'h55, 8'h55, 8'h55, 8'h12, 8'hD5, 8'h42, 8'h7E};
        drive_frame(-1, -1);
        send_good();
        wait_drained();
        end_test();

        // sparse credit return
        credit_mode <= 2'd2;
        repeat (4) send_good();
        wait_drained();
        end_test();

        // maximum frames into a store that nobody reads
        credit_mode <= 2'd0;
        repeat (4) @(posedge clk_io);
        drops_before = int'(rx_frames_dropped);
        // credits still held get spent on the first bytes that arrive
        lvl = -sb.credit_level;
        pred_drops = 0;
        repeat (4) begin
            build_frame(`GMII_RX_MAX_FRAME - 4);
            if (`GMII_RX_FIFO_DEPTH - ((lvl > 0) ? lvl : 0) >= `GMII_RX_MAX_FRAME) begin
                expect_frame(fcs_matches());
                lvl += frame_q.size();
            end else begin
                pred_drops++;
            end
            drive_frame(7, -1);
        end
        repeat (10) @(posedge clk_io);
        if (int'(rx_frames_dropped) - drops_before != pred_drops) begin
            $display("Fail %0t: %0d frames dropped, expected %0d", $time,
                     int'(rx_frames_dropped) - drops_before, pred_drops);
            bench_errors++;
        end
        credit_mode <= 2'd1;
        wait_drained();
        end_test();

        repeat (50) @(posedge clk_io);
        $display("tests %0d, failed %0d, errors %0d", test_num - 1, sb.tests_failed,
                 sb.error_count + bench_errors);
        if (sb.error_count + bench_errors == 0 && sb.tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
